/* common/nb_cfg_pkg.sv */
//--------------------------------------------------
// Neighbor store configuration
//--------------------------------------------------

package nb_cfg_pkg;

    // Picture size limits
    localparam int MAX_MB_WIDTH = 128;
    localparam int MB_ADDR_W    = 7;

    // APB address decode
    localparam int APB_ADDR_W = 8;

    //--------------------------------------------------
    // Register map
    //--------------------------------------------------
    // Bit 0 written as 1 starts a frame
    localparam logic [APB_ADDR_W-1:0] REG_CTRL      = 8'h00;
    localparam logic [APB_ADDR_W-1:0] REG_MB_WIDTH  = 8'h04;
    localparam logic [APB_ADDR_W-1:0] REG_MB_HEIGHT = 8'h08;
    // Busy, frame_done and current position, read only
    localparam logic [APB_ADDR_W-1:0] REG_STATUS    = 8'h0C;

endpackage

/* common/nb_pix_pkg.sv */
//--------------------------------------------------
// Neighbor sample types
//--------------------------------------------------

package nb_pix_pkg;

    typedef logic [7:0] sample_t;

    // Column 0 sits in byte 0
    typedef sample_t [15:0] luma_row_t;

    // Row 0 sits in byte 0
    typedef sample_t [15:0] luma_col_t;
    typedef sample_t [7:0]  chroma_col_t;

    // U in the low half, V in the high half
    typedef struct packed {
        chroma_col_t v;
        chroma_col_t u;
    } chroma_row_t;

    // Top row in bytes 0 to 15, top-right in bytes 16 to 19
    typedef sample_t [19:0] top_luma_t;

    localparam int TOP_RIGHT_W = 4;

    // Fill values for missing neighbors
    localparam sample_t FILL_LEFT = 8'd129;
    localparam sample_t FILL_TOP  = 8'd127;

endpackage

/* source/nb_apb_regs.sv */
//--------------------------------------------------
// APB control and status registers
//--------------------------------------------------
`timescale 1ns/1ps

module nb_apb_regs
    import nb_cfg_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [APB_ADDR_W-1:0] paddr,
    input  logic [31:0]           pwdata,
    output logic [31:0]           prdata,
    output logic                  pready,
    output logic                  pslverr,
    input  logic                  busy,
    input  logic                  frame_done,
    input  logic [MB_ADDR_W-1:0]  mb_x,
    input  logic [MB_ADDR_W-1:0]  mb_y,
    output logic                  frame_start,
    output logic [MB_ADDR_W-1:0]  mb_width,
    output logic [MB_ADDR_W-1:0]  mb_height
);

    logic        access;
    logic        wr_access;
    logic        illegal;
    logic [31:0] status;

    // No wait states
    assign pready    = 1'b1;
    assign access    = psel && penable;
    assign wr_access = access && pwrite;

    assign status = {9'b0, mb_y, 1'b0, mb_x, 6'b0, frame_done, busy};

    //--------------------------------------------------
    // Read mux and access checks
    //--------------------------------------------------
    always_comb begin
        prdata  = '0;
        illegal = 1'b0;
        case (paddr)
            REG_CTRL: begin
                // Start while a frame runs
                illegal = pwrite && pwdata[0] && busy;
            end
            REG_MB_WIDTH: begin
                prdata = {{(32-MB_ADDR_W){1'b0}}, mb_width};
            end
            REG_MB_HEIGHT: begin
                prdata = {{(32-MB_ADDR_W){1'b0}}, mb_height};
            end
            REG_STATUS: begin
                prdata  = status;
                illegal = pwrite;
            end
            default: begin
                illegal = 1'b1;
            end
        endcase
    end

    assign pslverr = access && illegal;

    //--------------------------------------------------
    // Size registers and start pulse
    //--------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mb_width    <= '0;
            mb_height   <= '0;
            frame_start <= 1'b0;
        end else begin
            frame_start <= wr_access && (paddr == REG_CTRL) && pwdata[0] && !busy;
            if (wr_access && (paddr == REG_MB_WIDTH)) begin
                mb_width <= pwdata[MB_ADDR_W-1:0];
            end
            if (wr_access && (paddr == REG_MB_HEIGHT)) begin
                mb_height <= pwdata[MB_ADDR_W-1:0];
            end
        end
    end

endmodule

/* neighbor/nb_sequencer.sv */
//--------------------------------------------------
// Macroblock sequencer
//--------------------------------------------------
`timescale 1ns/1ps

module nb_sequencer
    import nb_cfg_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 frame_start,
    input  logic [MB_ADDR_W-1:0] mb_width,
    input  logic [MB_ADDR_W-1:0] mb_height,
    input  logic                 edge_valid,
    output logic                 edge_ready,
    output logic                 nb_valid,
    output logic                 rd_en,
    output logic [MB_ADDR_W-1:0] rd_addr,
    output logic                 wr_en,
    output logic [MB_ADDR_W-1:0] wr_addr,
    output logic                 cap_top,
    output logic                 cap_top_right,
    output logic                 edge_take,
    output logic                 left_avail,
    output logic                 top_avail,
    output logic                 top_right_avail,
    output logic                 busy,
    output logic                 frame_done,
    output logic [MB_ADDR_W-1:0] mb_x,
    output logic [MB_ADDR_W-1:0] mb_y
);

    typedef enum logic [5:0] {
        S_IDLE  = 6'b000001,
        S_READ  = 6'b000010,
        S_WAIT  = 6'b000100,
        S_STORE = 6'b001000,
        S_VALID = 6'b010000,
        S_WRITE = 6'b100000
    } state_t;

    state_t state;
    state_t state_nxt;
    logic   last_col;
    logic   last_mb;
    logic   start;

    assign last_col = (mb_x == mb_width - 1'b1);
    assign last_mb  = last_col && (mb_y == mb_height - 1'b1);
    assign start    = frame_start && (state == S_IDLE);

    always_comb begin
        state_nxt = state;
        case (state)
            S_IDLE:  state_nxt = frame_start ? S_READ : S_IDLE;
            S_READ:  state_nxt = S_WAIT;
            S_WAIT:  state_nxt = S_STORE;
            S_STORE: state_nxt = S_VALID;
            // Hold here until the edge arrives
            S_VALID: state_nxt = edge_valid ? S_WRITE : S_VALID;
            S_WRITE: state_nxt = last_mb ? S_IDLE : S_READ;
            default: state_nxt = S_IDLE;
        endcase
    end

    //--------------------------------------------------
    // State, raster counters and done flag
    //--------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= S_IDLE;
            mb_x       <= '0;
            mb_y       <= '0;
            frame_done <= 1'b0;
        end else begin
            state <= state_nxt;
            if (start) begin
                mb_x       <= '0;
                mb_y       <= '0;
                frame_done <= 1'b0;
            end else if (state == S_WRITE) begin
                if (last_mb) begin
                    frame_done <= 1'b1;
                end else if (last_col) begin
                    mb_x <= '0;
                    mb_y <= mb_y + 1'b1;
                end else begin
                    mb_x <= mb_x + 1'b1;
                end
            end
        end
    end

    // Top row at x, then top-right at x+1
    assign rd_en   = (state == S_READ) || (state == S_WAIT);
    assign rd_addr = (state == S_WAIT) ? mb_x + 1'b1 : mb_x;

    assign cap_top       = (state == S_WAIT);
    assign cap_top_right = (state == S_STORE);

    assign nb_valid   = (state == S_VALID);
    assign edge_ready = nb_valid;
    assign edge_take  = nb_valid && edge_valid;

    // Bottom row is written in the transfer cycle itself
    assign wr_en   = edge_take;
    assign wr_addr = mb_x;

    assign left_avail      = (mb_x != '0);
    assign top_avail       = (mb_y != '0);
    assign top_right_avail = top_avail && !last_col;

    assign busy = (state != S_IDLE);

endmodule

/* neighbor/nb_line_buffer.sv */
//--------------------------------------------------
// Line buffer memory
//--------------------------------------------------
`timescale 1ns/1ps

module nb_line_buffer #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 128
) (
    input  logic                     clk,
    input  logic                     wr_en,
    input  logic [$clog2(DEPTH)-1:0] wr_addr,
    input  payload_t                 wr_data,
    input  logic                     rd_en,
    input  logic [$clog2(DEPTH)-1:0] rd_addr,
    output payload_t                 rd_data
);

    payload_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Read data lands one cycle after the address
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

/* neighbor/nb_assemble.sv */
//--------------------------------------------------
// Neighbor assembly and fills
//--------------------------------------------------
`timescale 1ns/1ps

module nb_assemble
    import nb_pix_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        cap_top,
    input  logic        cap_top_right,
    input  logic        edge_take,
    input  logic        left_avail,
    input  logic        top_avail,
    input  logic        top_right_avail,
    input  luma_row_t   luma_rd,
    input  chroma_row_t chroma_rd,
    input  luma_col_t   edge_right_y,
    input  chroma_col_t edge_right_u,
    input  chroma_col_t edge_right_v,
    output top_luma_t   top_y,
    output chroma_col_t top_u,
    output chroma_col_t top_v,
    output luma_col_t   left_y,
    output chroma_col_t left_u,
    output chroma_col_t left_v,
    output sample_t     top_left_y,
    output sample_t     top_left_u,
    output sample_t     top_left_v
);

    luma_row_t                  top_y_q;
    chroma_row_t                top_c_q;
    sample_t [TOP_RIGHT_W-1:0]  top_tr_q;
    luma_col_t                  left_y_q;
    chroma_col_t                left_u_q;
    chroma_col_t                left_v_q;
    sample_t                    corner_y_q;
    sample_t                    corner_u_q;
    sample_t                    corner_v_q;

    //--------------------------------------------------
    // Line buffer capture
    //--------------------------------------------------
    always_ff @(posedge clk) begin
        if (cap_top) begin
            top_y_q <= luma_rd;
            top_c_q <= chroma_rd;
        end
        // Only the first samples of the next column matter
        if (cap_top_right) begin
            top_tr_q <= luma_rd[TOP_RIGHT_W-1:0];
        end
    end

    // Right edge becomes the next left, last top sample the next corner
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            left_y_q   <= '0;
            left_u_q   <= '0;
            left_v_q   <= '0;
            corner_y_q <= '0;
            corner_u_q <= '0;
            corner_v_q <= '0;
        end else if (edge_take) begin
            left_y_q   <= edge_right_y;
            left_u_q   <= edge_right_u;
            left_v_q   <= edge_right_v;
            corner_y_q <= top_y_q[15];
            corner_u_q <= top_c_q.u[7];
            corner_v_q <= top_c_q.v[7];
        end
    end

    //--------------------------------------------------
    // Availability fills
    //--------------------------------------------------
    always_comb begin
        if (top_avail) begin
            top_y[15:0] = top_y_q;
            top_u       = top_c_q.u;
            top_v       = top_c_q.v;
            if (top_right_avail) begin
                top_y[19:16] = top_tr_q;
            end else begin
                top_y[19:16] = {TOP_RIGHT_W{top_y_q[15]}};
            end
        end else begin
            top_y = {20{FILL_TOP}};
            top_u = {8{FILL_TOP}};
            top_v = {8{FILL_TOP}};
        end
    end

    always_comb begin
        if (!left_avail) begin
            left_y     = {16{FILL_LEFT}};
            left_u     = {8{FILL_LEFT}};
            left_v     = {8{FILL_LEFT}};
            top_left_y = FILL_LEFT;
            top_left_u = FILL_LEFT;
            top_left_v = FILL_LEFT;
        end else begin
            left_y = left_y_q;
            left_u = left_u_q;
            left_v = left_v_q;
            // Corner follows the top row on the first picture row
            top_left_y = top_avail ? corner_y_q : FILL_TOP;
            top_left_u = top_avail ? corner_u_q : FILL_TOP;
            top_left_v = top_avail ? corner_v_q : FILL_TOP;
        end
    end

endmodule

/* source/intra_nb_top.sv */
//--------------------------------------------------
// Intra neighbor store top level
//--------------------------------------------------
`timescale 1ns/1ps

module intra_nb_top
    import nb_cfg_pkg::*;
    import nb_pix_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    // APB
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [APB_ADDR_W-1:0] paddr,
    input  logic [31:0]           pwdata,
    output logic [31:0]           prdata,
    output logic                  pready,
    output logic                  pslverr,
    // Reconstructed edges
    input  logic                  edge_valid,
    output logic                  edge_ready,
    input  luma_row_t             edge_bottom_y,
    input  chroma_col_t           edge_bottom_u,
    input  chroma_col_t           edge_bottom_v,
    input  luma_col_t             edge_right_y,
    input  chroma_col_t           edge_right_u,
    input  chroma_col_t           edge_right_v,
    // Neighbors
    output logic                  nb_valid,
    output top_luma_t             top_y,
    output chroma_col_t           top_u,
    output chroma_col_t           top_v,
    output luma_col_t             left_y,
    output chroma_col_t           left_u,
    output chroma_col_t           left_v,
    output sample_t               top_left_y,
    output sample_t               top_left_u,
    output sample_t               top_left_v
);

    logic                 frame_start;
    logic [MB_ADDR_W-1:0] mb_width;
    logic [MB_ADDR_W-1:0] mb_height;
    logic                 busy;
    logic                 frame_done;
    logic [MB_ADDR_W-1:0] mb_x;
    logic [MB_ADDR_W-1:0] mb_y;
    logic                 rd_en;
    logic [MB_ADDR_W-1:0] rd_addr;
    logic                 wr_en;
    logic [MB_ADDR_W-1:0] wr_addr;
    logic                 cap_top;
    logic                 cap_top_right;
    logic                 edge_take;
    logic                 left_avail;
    logic                 top_avail;
    logic                 top_right_avail;
    luma_row_t            luma_rd;
    chroma_row_t          chroma_rd;
    chroma_row_t          chroma_wr;

    assign chroma_wr = '{v: edge_bottom_v, u: edge_bottom_u};

    nb_apb_regs u_regs (
        .clk, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr,
        .busy, .frame_done, .mb_x, .mb_y,
        .frame_start, .mb_width, .mb_height
    );

    nb_sequencer u_seq (
        .clk, .rst_n, .frame_start, .mb_width, .mb_height, .edge_valid,
        .edge_ready, .nb_valid, .rd_en, .rd_addr, .wr_en, .wr_addr,
        .cap_top, .cap_top_right, .edge_take,
        .left_avail, .top_avail, .top_right_avail,
        .busy, .frame_done, .mb_x, .mb_y
    );

    //--------------------------------------------------
    // Bottom row storage, one entry per column
    //--------------------------------------------------
    nb_line_buffer #(.payload_t(luma_row_t), .DEPTH(MAX_MB_WIDTH)) u_luma_buf (
        .clk, .wr_en, .wr_addr, .wr_data(edge_bottom_y),
        .rd_en, .rd_addr, .rd_data(luma_rd)
    );

    nb_line_buffer #(.payload_t(chroma_row_t), .DEPTH(MAX_MB_WIDTH)) u_chroma_buf (
        .clk, .wr_en, .wr_addr, .wr_data(chroma_wr),
        .rd_en, .rd_addr, .rd_data(chroma_rd)
    );

    nb_assemble u_asm (
        .clk, .rst_n, .cap_top, .cap_top_right, .edge_take,
        .left_avail, .top_avail, .top_right_avail,
        .luma_rd, .chroma_rd, .edge_right_y, .edge_right_u, .edge_right_v,
        .top_y, .top_u, .top_v, .left_y, .left_u, .left_v,
        .top_left_y, .top_left_u, .top_left_v
    );

endmodule

/* tests/tb_clock_gen.sv */
//--------------------------------------------------
// Testbench clock and reset
//--------------------------------------------------
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Reset held for 8 cycles
    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

/* tests/intra_nb_checker.sv */
//--------------------------------------------------
// Neighbor store protocol assertions
//--------------------------------------------------
`timescale 1ns/1ps

module intra_nb_checker
    import nb_pix_pkg::*;
(
    input logic      clk,
    input logic      rst_n,
    input logic      frame_start,
    input logic      edge_valid,
    input logic      edge_ready,
    input logic      nb_valid,
    input logic      busy,
    input logic      frame_done,
    input top_luma_t top_y,
    input luma_col_t left_y,
    input sample_t   top_left_y
);

    int assert_errors = 0;

    // First neighbors four cycles after the start pulse
    start_to_valid: assert property (@(posedge clk) disable iff (!rst_n)
        frame_start |-> ##4 nb_valid)
        else begin
            assert_errors++;
            $error("nb_valid not raised 4 cycles after frame_start");
        end

    // One transfer per presented macroblock
    transfer_ends_valid: assert property (@(posedge clk) disable iff (!rst_n)
        edge_valid && edge_ready |=> !nb_valid)
        else begin
            assert_errors++;
            $error("nb_valid still high after an edge transfer");
        end

    //--------------------------------------------------
    // Back-pressure
    //--------------------------------------------------
    valid_held: assert property (@(posedge clk) disable iff (!rst_n)
        nb_valid && !edge_valid |=> nb_valid)
        else begin
            assert_errors++;
            $error("nb_valid dropped without an edge transfer");
        end

    neighbors_held: assert property (@(posedge clk) disable iff (!rst_n)
        nb_valid && !edge_valid |=> $stable(top_y) && $stable(left_y) && $stable(top_left_y))
        else begin
            assert_errors++;
            $error("neighbor outputs changed while waiting for the edge");
        end

    done_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !(busy && frame_done))
        else begin
            assert_errors++;
            $error("frame_done set while busy");
        end

endmodule

/* tests/tb_intra_nb.sv */
//--------------------------------------------------
// Intra neighbor store testbench
//--------------------------------------------------
`timescale 1ns/1ps

module tb_intra_nb
    import nb_cfg_pkg::*;
    import nb_pix_pkg::*;
();

    // Two frames of at most 12 macroblocks plus register traffic fit well inside
    localparam int TIMEOUT_CYCLES = 5000;

    logic                  clk;
    logic                  rst_n;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [APB_ADDR_W-1:0] paddr;
    logic [31:0]           pwdata;
    logic [31:0]           prdata;
    logic                  pready;
    logic                  pslverr;
    logic                  edge_valid;
    logic                  edge_ready;
    luma_row_t             edge_bottom_y;
    chroma_col_t           edge_bottom_u;
    chroma_col_t           edge_bottom_v;
    luma_col_t             edge_right_y;
    chroma_col_t           edge_right_u;
    chroma_col_t           edge_right_v;
    logic                  nb_valid;
    top_luma_t             top_y;
    chroma_col_t           top_u;
    chroma_col_t           top_v;
    luma_col_t             left_y;
    chroma_col_t           left_u;
    chroma_col_t           left_v;
    sample_t               top_left_y;
    sample_t               top_left_u;
    sample_t               top_left_v;

    //--------------------------------------------------
    // Reference model state
    //--------------------------------------------------
    luma_row_t   line_y [MAX_MB_WIDTH];
    chroma_col_t line_u [MAX_MB_WIDTH];
    chroma_col_t line_v [MAX_MB_WIDTH];
    luma_col_t   prev_right_y;
    chroma_col_t prev_right_u;
    chroma_col_t prev_right_v;
    luma_row_t   prev_top_y;
    chroma_col_t prev_top_u;
    chroma_col_t prev_top_v;
    top_luma_t   exp_top_y;
    chroma_col_t exp_top_u;
    chroma_col_t exp_top_v;
    luma_col_t   exp_left_y;
    chroma_col_t exp_left_u;
    chroma_col_t exp_left_v;
    sample_t     exp_tl_y;
    sample_t     exp_tl_u;
    sample_t     exp_tl_v;

    integer seed   = 32'hd9ce;
    int     errors = 0;
    int     checks = 0;
    int     cycles = 0;

    tb_clock_gen u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    intra_nb_top UUT (.*);

    bind intra_nb_top intra_nb_checker u_checker (.*);

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: no completion after %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic check(input string name, input logic [159:0] expected,
                         input logic [159:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    // Callers start 1 ns after a rising edge
    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                             output logic err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);
        err = pslverr;
        check("apb write pready", 1, pready);
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);
        data = prdata;
        err  = pslverr;
        check("apb read pready", 1, pready);
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // Counts the current cycle as 1, returns at the negedge where nb_valid is seen
    task automatic count_to_valid(output int n);
        logic seen;
        n    = 0;
        seen = 1'b0;
        while (!seen) begin
            n++;
            @(negedge clk);
            if (nb_valid) begin
                seen = 1'b1;
            end else begin
                @(posedge clk);
            end
        end
    endtask

    task automatic random_128(output logic [127:0] value);
        value = {$random(seed), $random(seed), $random(seed), $random(seed)};
    endtask

    task automatic compare_outputs(input string name);
        check({name, " top_y"}, exp_top_y, top_y);
        check({name, " top_u"}, exp_top_u, top_u);
        check({name, " top_v"}, exp_top_v, top_v);
        check({name, " left_y"}, exp_left_y, left_y);
        check({name, " left_u"}, exp_left_u, left_u);
        check({name, " left_v"}, exp_left_v, left_v);
        check({name, " top_left_y"}, exp_tl_y, top_left_y);
        check({name, " top_left_u"}, exp_tl_u, top_left_u);
        check({name, " top_left_v"}, exp_tl_v, top_left_v);
    endtask

    //--------------------------------------------------
    // One macroblock: check neighbors, stall, send edges
    //--------------------------------------------------
    task automatic process_mb(input string test, input int x, input int y, input int width,
                              input int height, input int max_stall);
        string        name;
        int           stall;
        int           lat;
        logic [127:0] rnd;
        name = $sformatf("%s mb %0d,%0d", test, x, y);
        if (y == 0) begin
            exp_top_y = {20{FILL_TOP}};
            exp_top_u = {8{FILL_TOP}};
            exp_top_v = {8{FILL_TOP}};
        end else begin
            exp_top_y[15:0] = line_y[x];
            exp_top_u       = line_u[x];
            exp_top_v       = line_v[x];
            if (x < width - 1) begin
                exp_top_y[19:16] = line_y[x + 1][3:0];
            end else begin
                exp_top_y[19:16] = {4{line_y[x][15]}};
            end
        end
        if (x == 0) begin
            exp_left_y = {16{FILL_LEFT}};
            exp_left_u = {8{FILL_LEFT}};
            exp_left_v = {8{FILL_LEFT}};
            exp_tl_y   = FILL_LEFT;
            exp_tl_u   = FILL_LEFT;
            exp_tl_v   = FILL_LEFT;
        end else begin
            exp_left_y = prev_right_y;
            exp_left_u = prev_right_u;
            exp_left_v = prev_right_v;
            exp_tl_y   = (y == 0) ? FILL_TOP : prev_top_y[15];
            exp_tl_u   = (y == 0) ? FILL_TOP : prev_top_u[7];
            exp_tl_v   = (y == 0) ? FILL_TOP : prev_top_v[7];
        end
        // Top row of this block is the corner source for the next one
        prev_top_y = line_y[x];
        prev_top_u = line_u[x];
        prev_top_v = line_v[x];

        check({name, " nb_valid"}, 1, nb_valid);
        check({name, " edge_ready"}, 1, edge_ready);
        compare_outputs(name);
        stall = $unsigned($random(seed)) % (max_stall + 1);
        repeat (stall) begin
            @(posedge clk);
            @(negedge clk);
            check({name, " hold nb_valid"}, 1, nb_valid);
            compare_outputs({name, " hold"});
        end

        @(posedge clk);
        #1;
        random_128(rnd);
        edge_bottom_y = rnd;
        random_128(rnd);
        edge_bottom_u = rnd[63:0];
        edge_bottom_v = rnd[127:64];
        random_128(rnd);
        edge_right_y = rnd;
        random_128(rnd);
        edge_right_u = rnd[63:0];
        edge_right_v = rnd[127:64];
        edge_valid   = 1'b1;
        @(posedge clk);
        #1;
        edge_valid = 1'b0;

        line_y[x]    = edge_bottom_y;
        line_u[x]    = edge_bottom_u;
        line_v[x]    = edge_bottom_v;
        prev_right_y = edge_right_y;
        prev_right_u = edge_right_u;
        prev_right_v = edge_right_v;
        if (!(x == width - 1 && y == height - 1)) begin
            count_to_valid(lat);
            check({name, " transfer to nb_valid"}, 5, lat);
        end
    endtask

    task automatic start_frame(input string name);
        logic err;
        int   lat;
        apb_write(REG_CTRL, 32'h1, err);
        check({name, " start pslverr"}, 0, err);
        // Start pulse lands one cycle after the write
        @(posedge clk);
        #1;
        count_to_valid(lat);
        check({name, " start to nb_valid"}, 4, lat);
    endtask

    //--------------------------------------------------
    // Directed tests
    //--------------------------------------------------
    task automatic test_registers();
        logic [31:0] data;
        logic        err;
        apb_read(REG_MB_WIDTH, data, err);
        check("registers width reset", 0, data);
        check("registers width pslverr", 0, err);
        apb_read(REG_MB_HEIGHT, data, err);
        check("registers height reset", 0, data);
        apb_read(REG_STATUS, data, err);
        check("registers status reset", 0, data);
        apb_write(REG_MB_WIDTH, 32'd3, err);
        check("registers width write pslverr", 0, err);
        apb_write(REG_MB_HEIGHT, 32'd2, err);
        apb_read(REG_MB_WIDTH, data, err);
        check("registers width readback", 3, data);
        apb_read(REG_MB_HEIGHT, data, err);
        check("registers height readback", 2, data);
        apb_read(8'h10, data, err);
        check("registers unmapped pslverr", 1, err);
        apb_write(REG_STATUS, 32'h1, err);
        check("registers status write pslverr", 1, err);
    endtask

    task automatic test_first_row();
        start_frame("first_row");
        for (int x = 0; x < 3; x++) begin
            process_mb("first_row", x, 0, 3, 2, 0);
        end
    endtask

    // Random stalls on this row exercise back-pressure
    task automatic test_second_row();
        for (int x = 0; x < 3; x++) begin
            process_mb("second_row", x, 1, 3, 2, 3);
        end
    endtask

    task automatic check_frame_end(input string name);
        logic [31:0] data;
        logic        err;
        repeat (6) begin
            @(negedge clk);
            check({name, " nb_valid low"}, 0, nb_valid);
            check({name, " edge_ready low"}, 0, edge_ready);
        end
        @(posedge clk);
        #1;
        apb_read(REG_STATUS, data, err);
        check({name, " status done and idle"}, 2'b10, data[1:0]);
    endtask

    task automatic test_restart();
        logic err;
        apb_write(REG_MB_WIDTH, 32'd4, err);
        apb_write(REG_MB_HEIGHT, 32'd1, err);
        start_frame("restart");
        @(posedge clk);
        #1;
        apb_write(REG_CTRL, 32'h1, err);
        check("restart start while busy pslverr", 1, err);
        @(negedge clk);
        for (int x = 0; x < 4; x++) begin
            process_mb("restart", x, 0, 4, 1, 2);
        end
        check_frame_end("restart end");
    endtask

    initial begin
        psel          = 1'b0;
        penable       = 1'b0;
        pwrite        = 1'b0;
        paddr         = '0;
        pwdata        = '0;
        edge_valid    = 1'b0;
        edge_bottom_y = '0;
        edge_bottom_u = '0;
        edge_bottom_v = '0;
        edge_right_y  = '0;
        edge_right_u  = '0;
        edge_right_v  = '0;
        @(posedge rst_n);
        @(posedge clk);
        #1;
        test_registers();
        test_first_row();
        test_second_row();
        check_frame_end("frame_end");
        test_restart();
        errors = errors + UUT.u_checker.assert_errors;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* filelist.f */
common/nb_cfg_pkg.sv
common/nb_pix_pkg.sv
source/nb_apb_regs.sv
neighbor/nb_sequencer.sv
neighbor/nb_line_buffer.sv
neighbor/nb_assemble.sv
source/intra_nb_top.sv
tests/tb_clock_gen.sv
tests/intra_nb_checker.sv
tests/tb_intra_nb.sv
